// File: rtl/cr16_pkg.sv
// shared widths, opcodes, FSM states and instruction views for the cr16 core, imported by every block
`default_nettype none

package cr16_pkg;

    // architecture widths
    localparam int data_w    = 16;
    localparam int pc_w      = 8;   // 256-word instruction memory
    localparam int reg_idx_w = 4;   // sixteen registers

    // opcodes, same code in ext (register form) and top nibble (immediate form)
    localparam logic [3:0] op_nop  = 4'h0;
    localparam logic [3:0] op_and  = 4'h1;
    localparam logic [3:0] op_or   = 4'h2;
    localparam logic [3:0] op_xor  = 4'h3;
    localparam logic [3:0] op_lsh  = 4'h4;
    localparam logic [3:0] op_add  = 4'h5;
    localparam logic [3:0] op_addu = 4'h6;
    localparam logic [3:0] op_addc = 4'h7;
    localparam logic [3:0] op_sub  = 4'h9;
    localparam logic [3:0] op_subc = 4'hA;
    localparam logic [3:0] op_cmp  = 4'hB;
    localparam logic [3:0] op_mov  = 4'hD;
    // 8 (not) and C (ashu) not implemented, decoded as nop

    // control FSM, one pass per instruction
    typedef enum logic [1:0] {
        st_fetch  = 2'd0,   // ir <= mem[pc], pc++
        st_decode = 2'd1,   // fields out, regfile read
        st_exec   = 2'd2    // alu, flags, writeback
    } state_t;

    // register form, top nibble zero
    typedef struct packed {
        logic [3:0]           major;  // always 0 here
        logic [reg_idx_w-1:0] rdest;
        logic [3:0]           ext;    // opcode
        logic [reg_idx_w-1:0] rsrc;
    } instr_rr_t;

    // immediate form, top nibble is the opcode
    typedef struct packed {
        logic [3:0]           op;     // nonzero
        logic [reg_idx_w-1:0] rdest;
        logic [7:0]           imm;
    } instr_imm_t;

    // same 16-bit word, two readings
    typedef union packed {
        instr_rr_t  rr;
        instr_imm_t im;
    } instr_t;

endpackage

`default_nettype wire

// File: rtl/cr16_fetch.sv
// instruction fetch for the cr16 core: program counter, loadable instruction memory and instruction register
`timescale 1ns/1ps
`default_nettype none

module cr16_fetch (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     run,
    input  logic                     prog_we,     // load strobe, one cycle
    input  logic [cr16_pkg::pc_w-1:0] prog_addr,
    input  cr16_pkg::instr_t         prog_data,
    input  logic                     pc_en,
    input  logic                     ir_en,
    output cr16_pkg::instr_t         instr
);
    import cr16_pkg::*;

    localparam int mem_depth = 1 << pc_w;

    instr_t           imem [0:mem_depth-1];   // filled through the program port
    logic [pc_w-1:0]  pc;
    instr_t           ir;

    // program load port works only while halted
    always_ff @(posedge clk) begin
        if (prog_we && !run) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // pc wraps 255 to 0 by width
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= '0;
        end else if (pc_en) begin
            pc <= pc + 1'b1;
        end
    end

    // instruction register
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir <= '0;   // reads as nop
        end else if (ir_en) begin
            ir <= imem[pc];   // word at the old pc
        end
    end

    assign instr = ir;

endmodule

`default_nettype wire

// File: rtl/cr16_control.sv
// control FSM and instruction decoder for the cr16 core, sequences fetch, decode and execute per instruction
`timescale 1ns/1ps
`default_nettype none

module cr16_control (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          run,
    input  cr16_pkg::instr_t              instr,    // from ir
    output logic                          pc_en,
    output logic                          ir_en,
    output logic                          reg_we,
    output logic                          exec_en,
    output logic                          imm_sel,  // high selects imm8 as operand
    output logic                          retire,   // one cycle per instruction
    output logic [3:0]                    op,
    output logic [cr16_pkg::reg_idx_w-1:0] rdest,
    output logic [cr16_pkg::reg_idx_w-1:0] rsrc,
    output logic [7:0]                    imm8
);
    import cr16_pkg::*;

    state_t     state;
    state_t     next_state;
    logic [3:0] raw_op;     // opcode before reserved mapping
    logic       is_rr;

    // supported subset only
    function automatic logic op_valid(input logic [3:0] code);
        case (code)
            op_and, op_or, op_xor, op_lsh,
            op_add, op_addu, op_addc,
            op_sub, op_subc, op_cmp, op_mov: op_valid = 1'b1;
            default:                          op_valid = 1'b0;   // nop, not, ashu, e, f
        endcase
    endfunction

    // state register
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= st_fetch;
        end else begin
            state <= next_state;
        end
    end

    // fixed three-cycle sequence that halts only in fetch
    always_comb begin
        case (state)
            st_fetch:  next_state = run ? st_decode : st_fetch;
            st_decode: next_state = st_exec;
            st_exec:   next_state = st_fetch;
            default:   next_state = st_fetch;
        endcase
    end

    // decode of the union
    always_comb begin
        is_rr = (instr.rr.major == 4'h0);
        if (is_rr) begin
            raw_op  = instr.rr.ext;
            imm_sel = 1'b0;
        end else begin
            raw_op  = instr.im.op;
            imm_sel = 1'b1;
        end
        rdest = instr.rr.rdest;   // same bits in both views
        rsrc  = instr.rr.rsrc;    // ignored in imm form
        imm8  = instr.im.imm;     // ignored in rr form
        op    = op_valid(raw_op) ? raw_op : op_nop;
    end

    // strobes from state
    always_comb begin
        pc_en   = (state == st_fetch) && run;
        ir_en   = (state == st_fetch) && run;
        exec_en = (state == st_exec);
        retire  = (state == st_exec);
        // cmp only sets flags and nop writes nothing
        reg_we  = (state == st_exec) && (op != op_nop) && (op != op_cmp);
    end

endmodule

`default_nettype wire

// File: rtl/cr16_regfile.sv
// cr16 register file, sixteen 16-bit registers with two read ports, one write port and a debug read port
`timescale 1ns/1ps
`default_nettype none

module cr16_regfile (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          we,
    input  logic [cr16_pkg::reg_idx_w-1:0] waddr,
    input  logic [cr16_pkg::reg_idx_w-1:0] raddr_a,
    input  logic [cr16_pkg::reg_idx_w-1:0] raddr_b,
    input  logic [cr16_pkg::reg_idx_w-1:0] dbg_addr,
    input  logic [cr16_pkg::data_w-1:0]    wdata,
    output logic [cr16_pkg::data_w-1:0]    rdata_a,
    output logic [cr16_pkg::data_w-1:0]    rdata_b,
    output logic [cr16_pkg::data_w-1:0]    dbg_data
);
    import cr16_pkg::*;

    localparam int num_regs = 1 << reg_idx_w;

    logic [data_w-1:0] regs [0:num_regs-1];

    // single write port, all cleared on reset
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a  = regs[raddr_a];    // rdest
    assign rdata_b  = regs[raddr_b];    // rsrc
    assign dbg_data = regs[dbg_addr];   // testbench peek

endmodule

`default_nettype wire

// File: rtl/cr16_execute.sv
// cr16 execute stage: operand select, immediate extension, ALU and the C F L N Z flag register
`timescale 1ns/1ps
`default_nettype none

module cr16_execute (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       exec_en,
    input  logic [3:0]                 op,
    input  logic                       imm_sel,
    input  logic [7:0]                 imm8,
    input  logic [cr16_pkg::data_w-1:0] rdest_data,
    input  logic [cr16_pkg::data_w-1:0] rsrc_data,
    output logic [cr16_pkg::data_w-1:0] result,
    output logic [4:0]                 flags    // {c, f, l, n, z}
);
    import cr16_pkg::*;

    logic [data_w-1:0] operand;
    logic              logic_op;     // and/or/xor take zero-extended imm
    logic [data_w:0]   sum;          // extra bit is carry
    logic [data_w:0]   diff;         // extra bit is borrow
    logic [4:0]        shamt;
    logic [4:0]        shmag;
    logic              flag_c, flag_f, flag_l, flag_n, flag_z;

    assign logic_op = (op == op_and) || (op == op_or) || (op == op_xor);

    // operand select
    always_comb begin
        if (!imm_sel) begin
            operand = rsrc_data;
        end else if (logic_op) begin
            operand = {{(data_w-8){1'b0}}, imm8};
        end else begin
            operand = {{(data_w-8){imm8[7]}}, imm8};
        end
    end

    // carry/borrow in only for addc/subc
    assign sum   = {1'b0, rdest_data} + {1'b0, operand}
                 + {{data_w{1'b0}}, (op == op_addc) && flag_c};
    assign diff  = {1'b0, rdest_data} - {1'b0, operand}
                 - {{data_w{1'b0}}, (op == op_subc) && flag_c};
    assign shamt = operand[4:0];                            // signed shift count
    assign shmag = shamt[4] ? (~shamt + 5'd1) : shamt;      // -16 -> 16

    always_comb begin
        case (op)
            op_and:                   result = rdest_data & operand;
            op_or:                    result = rdest_data | operand;
            op_xor:                   result = rdest_data ^ operand;
            op_add, op_addu, op_addc: result = sum[data_w-1:0];
            op_sub, op_subc:          result = diff[data_w-1:0];
            op_mov:                   result = operand;
            op_lsh:                   result = shamt[4] ? (rdest_data >> shmag)   // logical
                                                        : (rdest_data << shmag);
            default:                  result = rdest_data;   // cmp, nop, not written
        endcase
    end

    // flag register, per opcode
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            {flag_c, flag_f, flag_l, flag_n, flag_z} <= '0;
        end else if (exec_en) begin
            case (op)
                op_add, op_addc: begin
                    flag_c <= sum[data_w];
                    flag_f <= (rdest_data[data_w-1] == operand[data_w-1]) &&
                              (sum[data_w-1] != rdest_data[data_w-1]);
                end
                op_sub, op_subc: begin
                    flag_c <= diff[data_w];   // borrow
                    flag_f <= (rdest_data[data_w-1] != operand[data_w-1]) &&
                              (diff[data_w-1] != rdest_data[data_w-1]);
                end
                op_cmp: begin
                    flag_z <= (rdest_data == operand);
                    flag_l <= (rdest_data < operand);
                    flag_n <= ($signed(rdest_data) < $signed(operand));
                end
                default: ;   // flags hold
            endcase
        end
    end

    assign flags = {flag_c, flag_f, flag_l, flag_n, flag_z};

endmodule

`default_nettype wire

// File: rtl/cr16_core.sv
// top level of the multicycle cr16 core, wires fetch, control, register file and execute together
`timescale 1ns/1ps
`default_nettype none

module cr16_core (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          run,
    input  logic                          prog_we,
    input  logic [cr16_pkg::pc_w-1:0]      prog_addr,
    input  cr16_pkg::instr_t              prog_data,
    input  logic [cr16_pkg::reg_idx_w-1:0] dbg_addr,
    output logic [cr16_pkg::data_w-1:0]    dbg_data,
    output logic [4:0]                    flags,     // {c, f, l, n, z}
    output logic                          retire
);
    import cr16_pkg::*;

    instr_t               instr;
    logic                 pc_en, ir_en, reg_we, exec_en, imm_sel;
    logic [3:0]           op;
    logic [reg_idx_w-1:0] rdest, rsrc;
    logic [7:0]           imm8;
    logic [data_w-1:0]    rdest_data, rsrc_data, result;

    cr16_fetch cr16_fetch_inst (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pc_en     (pc_en),
        .ir_en     (ir_en),
        .instr     (instr)
    );

    cr16_control cr16_control_inst (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .instr   (instr),
        .pc_en   (pc_en),
        .ir_en   (ir_en),
        .reg_we  (reg_we),
        .exec_en (exec_en),
        .imm_sel (imm_sel),
        .retire  (retire),
        .op      (op),
        .rdest   (rdest),
        .rsrc    (rsrc),
        .imm8    (imm8)
    );

    // port a is rdest, also the write address
    cr16_regfile cr16_regfile_inst (
        .clk      (clk),
        .reset    (reset),
        .we       (reg_we),
        .waddr    (rdest),
        .raddr_a  (rdest),
        .raddr_b  (rsrc),
        .dbg_addr (dbg_addr),
        .wdata    (result),
        .rdata_a  (rdest_data),
        .rdata_b  (rsrc_data),
        .dbg_data (dbg_data)
    );

    cr16_execute cr16_execute_inst (
        .clk        (clk),
        .reset      (reset),
        .exec_en    (exec_en),
        .op         (op),
        .imm_sel    (imm_sel),
        .imm8       (imm8),
        .rdest_data (rdest_data),
        .rsrc_data  (rsrc_data),
        .result     (result),
        .flags      (flags)
    );

endmodule

`default_nettype wire

// File: verification/cr16_clock_gen.sv
// clock and reset source for the cr16 testbench, 4 ns clock and a reset task called between tests
`timescale 1ns/1ps
`default_nettype none

module cr16_clock_gen (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    initial reset = 1'b0;   // asserted from time zero

    // active low for 4 cycles, edges on falling clock
    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b1;
    endtask

endmodule

`default_nettype wire

// File: verification/cr16_core_tb.sv
// directed tests for the cr16 core with a register and flag model; run through the Makefile sim target
`timescale 1ns/1ps
`default_nettype none

module cr16_core_tb;
    import cr16_pkg::*;

    logic                 clk, reset, run, prog_we, retire;
    logic [pc_w-1:0]      prog_addr;
    instr_t               prog_data;
    logic [reg_idx_w-1:0] dbg_addr;
    logic [data_w-1:0]    dbg_data;
    logic [4:0]           flags;

    logic [15:0] prog [$];           // program of the current run
    logic [15:0] m_regs [16];        // model registers
    logic [4:0]  m_flags;            // model {c, f, l, n, z}
    logic [15:0] seen_regs [16];     // dut registers read back after a run

    cr16_clock_gen cr16_clock_gen_inst (.clk(clk), .reset(reset));

    cr16_core cr16_core_inst (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data),
        .flags     (flags),
        .retire    (retire)
    );

    function automatic logic [15:0] reg_form(input logic [3:0] op, rd, rs);
        return {4'h0, rd, op, rs};
    endfunction

    function automatic logic [15:0] imm_form(input logic [3:0] op, rd, input logic [7:0] imm);
        return {op, rd, imm};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // builds a full 16-bit constant from mov, lsh and or
    task automatic load_const(input logic [3:0] rd, input logic [15:0] value);
        prog.push_back(imm_form(op_mov, rd, value[15:8]));
        prog.push_back(imm_form(op_lsh, rd, 8'h08));
        prog.push_back(imm_form(op_or, rd, value[7:0]));   // zero-extended
    endtask

    // one instruction applied to the model registers and flags
    task automatic model_step(input logic [15:0] w);
        logic [3:0]  op;
        logic [3:0]  rd;
        logic [15:0] a, b, res;
        logic        cin;
        int          sa, sb, sr, ur, amt;
        op = (w[15:12] == 4'h0) ? w[7:4] : w[15:12];
        rd = w[11:8];
        a  = m_regs[rd];
        if (w[15:12] == 4'h0) begin
            b = m_regs[w[3:0]];
        end else if (op inside {op_and, op_or, op_xor}) begin
            b = {8'h00, w[7:0]};
        end else begin
            b = {{8{w[7]}}, w[7:0]};
        end
        cin = (op == op_addc || op == op_subc) ? m_flags[4] : 1'b0;
        sa  = $signed(a);
        sb  = $signed(b);
        res = a;
        case (op)
            op_and:  res = a & b;
            op_or:   res = a | b;
            op_xor:  res = a ^ b;
            op_mov:  res = b;
            op_addu: res = a + b;   // flags untouched
            op_lsh: begin
                amt = $signed(b[4:0]);   // -16 .. 15
                res = (amt >= 0) ? (a << amt) : (a >> (-amt));
            end
            op_add, op_addc: begin
                sr = sa + sb + int'(cin);
                ur = int'(a) + int'(b) + int'(cin);
                res = ur[15:0];
                m_flags[4] = (ur > 65535);
                m_flags[3] = (sr > 32767) || (sr < -32768);
            end
            op_sub, op_subc: begin
                sr = sa - sb - int'(cin);
                ur = int'(a) - int'(b) - int'(cin);
                res = ur[15:0];
                m_flags[4] = (ur < 0);   // borrow
                m_flags[3] = (sr > 32767) || (sr < -32768);
            end
            op_cmp: begin
                m_flags[0] = (a == b);
                m_flags[2] = (int'(a) < int'(b));
                m_flags[1] = (sa < sb);
            end
            default: ;   // nop and reserved
        endcase
        if (op inside {op_and, op_or, op_xor, op_lsh, op_add, op_addu, op_addc,
                       op_sub, op_subc, op_mov}) begin
            m_regs[rd] = res;
        end
    endtask

    // reset, load, run to the last retire, then compare all registers and flags
    task automatic run_program(input string name);
        int count;
        int cycles;
        for (int i = 0; i < 16; i++) begin
            m_regs[i] = '0;
        end
        m_flags = '0;
        run     = 1'b0;
        cr16_clock_gen_inst.apply_reset();
        for (int a = 0; a < 256; a++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = a[7:0];
            // register-form nop that encodes the address
            prog_data = (a < prog.size()) ? prog[a] : {4'h0, a[7:4], 4'h0, a[3:0]};
        end
        @(negedge clk);
        prog_we = 1'b0;
        foreach (prog[i]) begin
            model_step(prog[i]);
        end
        run    = 1'b1;
        count  = 0;
        cycles = 0;
        while (count < prog.size()) begin
            @(negedge clk);
            cycles++;
            if (retire) begin
                count++;
            end else if (cycles > 10 * prog.size()) begin
                abort_run($sformatf("%s: timeout, only %0d of %0d instructions retired",
                                    name, count, prog.size()));
            end
        end
        run = 1'b0;   // halts in fetch after the next edge
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            dbg_addr = 4'(i);
            @(posedge clk);
            seen_regs[i] = dbg_data;
            check_value($sformatf("%s r%0d", name, i), dbg_data, m_regs[i]);
        end
        check_value({name, " flags"}, flags, m_flags);
    endtask

    task automatic mov_and_nop();
        prog = {};
        prog.push_back(imm_form(op_mov, 4'd1, 8'h80));   // negative byte
        prog.push_back(imm_form(op_mov, 4'd2, 8'h7F));
        prog.push_back(imm_form(op_mov, 4'd3, 8'hFF));
        prog.push_back(16'h0000);                        // nop
        prog.push_back(imm_form(4'h8, 4'd1, 8'h12));     // reserved opcodes
        prog.push_back(imm_form(4'hC, 4'd2, 8'h34));
        prog.push_back(reg_form(4'hE, 4'd3, 4'd1));
        run_program("mov");
        check_value("mov r1", seen_regs[1], 16'hFF80);
        check_value("mov r2", seen_regs[2], 16'h007F);
        check_value("mov r3", seen_regs[3], 16'hFFFF);
        check_value("mov flags", flags, 5'b00000);
    endtask

    task automatic add_sub_flags();
        prog = {};
        load_const(4'd1, 16'h7FFF);
        prog.push_back(imm_form(op_add, 4'd1, 8'h01));    // signed overflow
        run_program("add ovf");
        check_value("add ovf r1", seen_regs[1], 16'h8000);
        check_value("add ovf flags", flags, 5'b01000);
        prog = {};
        load_const(4'd1, 16'hFFFF);
        prog.push_back(imm_form(op_mov, 4'd2, 8'h01));
        prog.push_back(reg_form(op_add, 4'd1, 4'd2));     // carry out
        prog.push_back(imm_form(op_addu, 4'd3, 8'hFB));   // flags kept
        prog.push_back(reg_form(op_addu, 4'd3, 4'd2));    // register form keeps flags too
        run_program("add carry");
        check_value("add carry r3", seen_regs[3], 16'hFFFC);
        check_value("add carry flags", flags, 5'b10000);
        prog = {};
        load_const(4'd1, 16'h8000);
        prog.push_back(imm_form(op_mov, 4'd2, 8'h03));
        prog.push_back(imm_form(op_sub, 4'd1, 8'h01));
        prog.push_back(reg_form(op_sub, 4'd2, 4'd1));     // 3 - 7fff borrows
        run_program("sub");
        check_value("sub r2", seen_regs[2], 16'h8004);
        check_value("sub flags", flags, 5'b10000);
    endtask

    // 0001_ffff + 0000_0001, then 0005_0000 - 0000_0001
    task automatic wide_add_sub();
        prog = {};
        load_const(4'd2, 16'hFFFF);
        load_const(4'd3, 16'h0001);
        load_const(4'd4, 16'h0001);
        prog.push_back(imm_form(op_mov, 4'd5, 8'h00));
        prog.push_back(reg_form(op_add, 4'd2, 4'd4));
        prog.push_back(reg_form(op_addc, 4'd3, 4'd5));
        load_const(4'd6, 16'h0000);
        load_const(4'd7, 16'h0005);
        prog.push_back(reg_form(op_sub, 4'd6, 4'd4));
        prog.push_back(reg_form(op_subc, 4'd7, 4'd5));
        run_program("wide");
        check_value("wide sum lo", seen_regs[2], 16'h0000);
        check_value("wide sum hi", seen_regs[3], 16'h0002);
        check_value("wide diff lo", seen_regs[6], 16'hFFFF);
        check_value("wide diff hi", seen_regs[7], 16'h0004);
    endtask

    task automatic compare_flags();
        prog = {};
        prog.push_back(imm_form(op_mov, 4'd1, 8'h05));
        prog.push_back(imm_form(op_cmp, 4'd1, 8'h05));    // equal
        run_program("cmp eq");
        check_value("cmp eq flags", flags, 5'b00001);
        prog = {};
        prog.push_back(imm_form(op_mov, 4'd1, 8'h05));
        prog.push_back(imm_form(op_mov, 4'd2, 8'hFF));
        prog.push_back(reg_form(op_cmp, 4'd1, 4'd2));     // 5 below ffff unsigned
        run_program("cmp lo");
        check_value("cmp lo flags", flags, 5'b00100);
        prog = {};
        prog.push_back(imm_form(op_mov, 4'd1, 8'hFF));
        prog.push_back(imm_form(op_cmp, 4'd1, 8'h05));    // -1 below 5 signed
        run_program("cmp lt");
        check_value("cmp lt r1", seen_regs[1], 16'hFFFF);
        check_value("cmp lt flags", flags, 5'b00010);
    endtask

    task automatic logic_and_shift();
        prog = {};
        load_const(4'd1, 16'hA5C3);
        for (int r = 2; r < 8; r++) begin
            prog.push_back(reg_form(op_mov, 4'(r), 4'd1));
        end
        prog.push_back(imm_form(op_and, 4'd2, 8'hF0));
        prog.push_back(imm_form(op_or, 4'd3, 8'hBC));
        prog.push_back(imm_form(op_xor, 4'd4, 8'hFF));
        prog.push_back(imm_form(op_lsh, 4'd5, 8'h03));    // +3
        prog.push_back(imm_form(op_lsh, 4'd6, 8'hFC));    // -4
        prog.push_back(imm_form(op_lsh, 4'd7, 8'hF0));    // -16
        run_program("logic");
        check_value("and r2", seen_regs[2], 16'h00C0);
        check_value("or r3", seen_regs[3], 16'hA5FF);
        check_value("xor r4", seen_regs[4], 16'hA53C);
        check_value("lsh r5", seen_regs[5], 16'h2E18);
        check_value("lsh r6", seen_regs[6], 16'h0A5C);
        check_value("lsh r7", seen_regs[7], 16'h0000);
    endtask

    task automatic random_program();
        logic [3:0] ops [11] = '{op_and, op_or, op_xor, op_lsh, op_add, op_addu,
                                 op_addc, op_sub, op_subc, op_cmp, op_mov};
        logic [3:0] op;
        prog = {};
        for (int r = 0; r < 16; r++) begin
            load_const(4'(r), 16'($urandom));
        end
        for (int i = 0; i < 60; i++) begin
            op = ops[$urandom % 11];
            if ($urandom % 2 == 0) begin
                prog.push_back(reg_form(op, 4'($urandom), 4'($urandom)));
            end else begin
                prog.push_back(imm_form(op, 4'($urandom), 8'($urandom)));
            end
        end
        run_program("random");
    endtask

    initial begin
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        dbg_addr  = '0;
        void'($urandom(32'ha456_bc68));
        mov_and_nop();
        add_sub_flags();
        wide_add_sub();
        compare_flags();
        logic_and_shift();
        random_program();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: cr16_core.f
rtl/cr16_pkg.sv
rtl/cr16_fetch.sv
rtl/cr16_control.sv
rtl/cr16_regfile.sv
rtl/cr16_execute.sv
rtl/cr16_core.sv
verification/cr16_clock_gen.sv
verification/cr16_core_tb.sv

// File: Makefile
# Verilator build and run of the cr16 core testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module cr16_core_tb \
		-f cr16_core.f -Mdir obj_dir -o cr16_core_sim
	./obj_dir/cr16_core_sim 2>&1 | tee sim.log
	@if grep -q "\*\*\* FAILED \*\*\*" sim.log; then exit 1; fi
	@grep -q "\*\*\* PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log
